// ==== logic/main_pkg.sv ====
/*
 * shared widths and memory-map codes for the main board glue logic
 * io page codes are address bits 9..7 inside the 0x1400 page
 * latch indices are address bits 2..0 of the 0x1480 output latch
 */
package main_pkg;

    // bus widths
    typedef logic [15:0] addr_t;    // cpu address
    typedef logic [7:0]  data_t;    // cpu data byte
    typedef logic [6:0]  joy_t;     // 3 buttons + 4 directions
    typedef logic [7:0]  dip_t;     // one dip bank
    typedef logic [2:0]  io_code_t; // select inside the io page
    typedef logic [2:0]  latch_idx_t;

    // rom starts here and runs to the top of the map
    localparam addr_t rom_base = 16'h4000;

    // 0x1400 page, decoded by a[9:7]
    localparam io_code_t io_intst = 3'd0; // 0x1400 irq status / frame strobe
    localparam io_code_t io_iow   = 3'd1; // 0x1480 output latch
    localparam io_code_t io_snd   = 3'd2; // 0x1500 sound latch
    localparam io_code_t io_in5   = 3'd4; // 0x1600 dip bank b
    localparam io_code_t io_ior   = 3'd5; // 0x1680 cabinet inputs

    // output latch bits, written with data bit 0
    localparam latch_idx_t latch_flip    = 3'd0;
    localparam latch_idx_t latch_snd_irq = 3'd1;
    localparam latch_idx_t latch_irq_en  = 3'd7; // low also clears the irq ff

    // value seen on reads from unmapped space
    localparam data_t open_bus = 8'hff;

endpackage

// ==== logic/main_if.sv ====
/*
 * cpu bus and chip select bundles
 * the bus master holds addr/rnw/vma/wdata for a full cen period
 * at most one select is high at any time
 */

interface cpu_bus_if;
    main_pkg::addr_t addr;  // cpu address
    logic            rnw;   // 1 read, 0 write
    logic            vma;   // valid memory access
    main_pkg::data_t wdata; // cpu write data
    logic            cen;   // cpu clock enable, one clk wide

    modport master (
        output addr, rnw, vma, wdata, cen
    );

    modport slave (
        input addr, rnw, vma, wdata, cen
    );
endinterface

interface sel_if;
    logic rom;      // 0x4000-0xffff, reads only
    logic ram;      // work ram, two windows
    logic vram;     // lower half of 0x2000 window
    logic objram;   // 0x1000-0x13ff
    logic ior;      // cabinet inputs
    logic in5;      // dip bank b
    logic iow;      // output latch
    logic intst;    // frame strobe
    logic snd;      // sound latch

    modport decoder (
        output rom, ram, vram, objram, ior, in5, iow, intst, snd
    );

    modport user (
        input rom, ram, vram, objram, ior, in5, iow, intst, snd
    );
endinterface

// ==== logic/addr_decoder.sv ====
/*
 * combinational memory map decode, no registers
 * 0x2000 window is split by a[5]: set is work ram, clear is video ram
 * unmapped space raises no select at all
 */
module addr_decoder (
    cpu_bus_if.slave bus,
    sel_if.decoder   sel
);

    always_comb begin
        // all low unless the map below hits
        sel.rom    = 1'b0;
        sel.ram    = 1'b0;
        sel.vram   = 1'b0;
        sel.objram = 1'b0;
        sel.ior    = 1'b0;
        sel.in5    = 1'b0;
        sel.iow    = 1'b0;
        sel.intst  = 1'b0;
        sel.snd    = 1'b0;

        if (bus.vma) begin
            if (bus.addr >= main_pkg::rom_base) begin
                sel.rom = bus.rnw; // rom ignores writes
            end else if (bus.addr[15:13] == 3'd1) begin
                // 0x2000-0x3fff
                case (bus.addr[12:11])
                    2'd0: begin
                        // half the scroll ram is used as plain work ram
                        if (bus.addr[5])
                            sel.ram = 1'b1;
                        else
                            sel.vram = 1'b1;
                    end
                    2'd2, 2'd3: sel.ram = 1'b1; // 0x3000-0x3fff
                    default: ;                  // 0x2800-0x2fff open
                endcase
            end else if (bus.addr[15:13] == 3'd0) begin
                // 0x0000-0x1fff, only 0x1000-0x17ff in use
                case (bus.addr[12:10])
                    3'd4: sel.objram = 1'b1;
                    3'd5: begin
                        // io page, 128 byte slots
                        case (bus.addr[9:7])
                            main_pkg::io_intst: sel.intst = 1'b1;
                            main_pkg::io_iow:   sel.iow   = 1'b1;
                            main_pkg::io_snd:   sel.snd   = 1'b1;
                            main_pkg::io_in5:   sel.in5   = 1'b1;
                            main_pkg::io_ior:   sel.ior   = 1'b1;
                            default: ;          // 0x1580, 0x1700, 0x1780 open
                        endcase
                    end
                    default: ;
                endcase
            end
        end
    end

    // sampled once per cpu cycle, when the bus is settled
    a_onehot_sel: assert property (
        @(posedge bus.cen)
        $onehot0({sel.rom, sel.ram, sel.vram, sel.objram, sel.ior,
                  sel.in5, sel.iow, sel.intst, sel.snd})
    ) else $error("addr_decoder: more than one select at %h", bus.addr);

endmodule

// ==== logic/work_ram.sv ====
/*
 * single port byte ram, no reset on contents
 * writes on cen, reads every clk with one clk latency
 * low ram_aw address bits only, a small ram_aw mirrors the windows
 */
module work_ram #(
    parameter int ram_aw = 13
) (
    input  logic            clk,
    cpu_bus_if.slave        bus,
    sel_if.user             sel,
    output main_pkg::data_t dout
);

    main_pkg::data_t mem [2**ram_aw];

    logic [ram_aw-1:0] ram_addr;
    logic              we;

    assign ram_addr = bus.addr[ram_aw-1:0];
    assign we       = bus.cen & sel.ram & ~bus.rnw; // one write per cpu cycle

    always_ff @(posedge clk) begin
        if (we)
            mem[ram_addr] <= bus.wdata;
        dout <= mem[ram_addr]; // read path runs regardless of select
    end

    // a write lands only from a valid, settled write cycle
    a_write_ok: assert property (
        @(posedge clk) we |-> (!bus.rnw && bus.vma && $stable(bus.addr))
    ) else $error("work_ram: bad write at %h", bus.addr);

endmodule

// ==== logic/read_mux.sv ====
/*
 * cpu read data path, registered, resets to 0xff
 * cabinet byte picked by a[1:0] inside the ior slot
 * joystick directions are reordered to the board wiring
 */
module read_mux (
    input  logic             clk,
    input  logic             rst,
    cpu_bus_if.slave         bus,
    sel_if.user              sel,
    input  main_pkg::data_t  rom_data,
    input  main_pkg::data_t  vram_dout,
    input  main_pkg::data_t  obj_dout,
    input  main_pkg::data_t  ram_dout,
    input  logic [1:0]       start_button,
    input  logic [1:0]       coin_input,
    input  logic             service,
    input  main_pkg::joy_t   joystick1,
    input  main_pkg::joy_t   joystick2,
    input  main_pkg::dip_t   dipsw_a,
    input  main_pkg::dip_t   dipsw_b,
    input  logic [2:0]       dipsw_c,   // board jumpers
    output main_pkg::data_t  cpu_din
);

    main_pkg::data_t cabinet;
    main_pkg::data_t rd_next;

    // cabinet byte
    always_comb begin
        case (bus.addr[1:0])
            2'd0: cabinet = {dipsw_c, start_button, service, coin_input};
            2'd1: cabinet = {1'b1, joystick1[6:4],   // buttons
                             joystick1[2], joystick1[3],
                             joystick1[0], joystick1[1]};
            2'd2: cabinet = {1'b1, joystick2[6:4],
                             joystick2[2], joystick2[3],
                             joystick2[0], joystick2[1]};
            default: cabinet = dipsw_a;
        endcase
    end

    // priority order, the selects are one-hot anyway
    always_comb begin
        if (sel.rom)
            rd_next = rom_data;
        else if (sel.vram)
            rd_next = vram_dout;
        else if (sel.ram)
            rd_next = ram_dout;   // already one clk late
        else if (sel.objram)
            rd_next = obj_dout;
        else if (sel.ior)
            rd_next = cabinet;
        else if (sel.in5)
            rd_next = dipsw_b;
        else
            rd_next = main_pkg::open_bus; // unmapped
    end

    always_ff @(posedge clk) begin
        if (rst)
            cpu_din <= main_pkg::open_bus;
        else
            cpu_din <= rd_next; // updates every clk, cpu samples on cen
    end

endmodule

// ==== logic/ctrl_latch.sv ====
/*
 * output latch (8 addresses, data bit 0), frame toggle and vblank irq
 * latch and frame toggle move only on cen
 * irq is set on the rising vblank edge, held clear while irq_en is 0
 */
module ctrl_latch (
    input  logic     clk,
    input  logic     rst,
    cpu_bus_if.slave bus,
    sel_if.user      sel,
    input  logic     lvbl,      // vertical blank, active low
    input  logic     dip_pause, // low pauses the game
    output logic     flip,
    output logic     snd_irq,
    output logic     obj_frame,
    output logic     irq_n
);

    logic irq_en;   // latch bit 7
    logic intst_l;  // intst seen on the last cen
    logic trig;
    logic trig_l;
    logic irq_q;

    assign trig  = ~lvbl & dip_pause; // no irq while paused
    assign irq_n = ~irq_q;

    // addressable latch and frame toggle
    always_ff @(posedge clk) begin
        if (rst) begin
            flip      <= 1'b0;
            snd_irq   <= 1'b0;
            irq_en    <= 1'b0;
            obj_frame <= 1'b0;
            intst_l   <= 1'b0;
        end else if (bus.cen) begin
            intst_l <= sel.intst;
            if (sel.intst && !intst_l)
                obj_frame <= ~obj_frame; // one flip per strobe access
            if (sel.iow && !bus.rnw) begin
                case (bus.addr[2:0])
                    main_pkg::latch_flip:    flip    <= bus.wdata[0];
                    main_pkg::latch_snd_irq: snd_irq <= bus.wdata[0];
                    main_pkg::latch_irq_en:  irq_en  <= bus.wdata[0];
                    default: ;  // coin counters and spare outputs
                endcase
            end
        end
    end

    // vblank irq ff, edge set / level clear
    always_ff @(posedge clk) begin
        if (rst) begin
            trig_l <= 1'b0;
            irq_q  <= 1'b0;
        end else begin
            trig_l <= trig;                // sampled every clk
            if (!irq_en)
                irq_q <= 1'b0;             // clear wins over set
            else if (trig && !trig_l)
                irq_q <= 1'b1;
        end
    end

    // a disabled irq releases the line by the next clk
    a_irq_masked: assert property (
        @(posedge clk) disable iff (rst) !irq_en |=> irq_n
    ) else $error("ctrl_latch: irq_n low while irq disabled");

endmodule

// ==== logic/main_board.sv ====
/*
 * main board glue around an external 6809-class cpu
 * cpu bus comes in as plain ports, sampled on cpu_cen
 * no wait states here, the cpu wrapper stalls cpu_cen for slow rom
 */
module main_board #(
    parameter int ram_aw = 13  // work ram address width
) (
    input  logic             clk,
    input  logic             rst,
    // cpu bus
    input  logic             cpu_cen,
    input  main_pkg::addr_t  addr,
    input  logic             rnw,
    input  logic             vma,
    input  main_pkg::data_t  cpu_dout,
    output main_pkg::data_t  cpu_din,
    // rom
    output main_pkg::addr_t  rom_addr,
    input  main_pkg::data_t  rom_data,
    // video and sound side
    input  main_pkg::data_t  vram_dout,
    input  main_pkg::data_t  obj_dout,
    output logic             vram_cs,
    output logic             objram_cs,
    output logic             snd_data_cs,
    output logic             obj_frame,
    output logic             flip,
    output logic             snd_irq,
    output logic             irq_n,
    // cabinet
    input  logic [1:0]       start_button,
    input  logic [1:0]       coin_input,
    input  logic             service,
    input  main_pkg::joy_t   joystick1,
    input  main_pkg::joy_t   joystick2,
    // dips and timing
    input  main_pkg::dip_t   dipsw_a,
    input  main_pkg::dip_t   dipsw_b,
    input  logic [2:0]       dipsw_c,
    input  logic             lvbl,
    input  logic             dip_pause
);

    cpu_bus_if bus ();
    sel_if     sel ();

    main_pkg::data_t ram_dout;

    // fill the bus from the cpu ports
    assign bus.addr  = addr;
    assign bus.rnw   = rnw;
    assign bus.vma   = vma;
    assign bus.wdata = cpu_dout;
    assign bus.cen   = cpu_cen;

    assign rom_addr    = addr;       // same cycle as the address
    assign vram_cs     = sel.vram;
    assign objram_cs   = sel.objram;
    assign snd_data_cs = sel.snd;

    addr_decoder u_dec (
        .bus (bus),
        .sel (sel)
    );

    work_ram #(.ram_aw(ram_aw)) u_ram (
        .clk  (clk),
        .bus  (bus),
        .sel  (sel),
        .dout (ram_dout)
    );

    read_mux u_mux (
        .clk          (clk),
        .rst          (rst),
        .bus          (bus),
        .sel          (sel),
        .rom_data     (rom_data),
        .vram_dout    (vram_dout),
        .obj_dout     (obj_dout),
        .ram_dout     (ram_dout),
        .start_button (start_button),
        .coin_input   (coin_input),
        .service      (service),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .dipsw_a      (dipsw_a),
        .dipsw_b      (dipsw_b),
        .dipsw_c      (dipsw_c),
        .cpu_din      (cpu_din)
    );

    ctrl_latch u_latch (
        .clk       (clk),
        .rst       (rst),
        .bus       (bus),
        .sel       (sel),
        .lvbl      (lvbl),
        .dip_pause (dip_pause),
        .flip      (flip),
        .snd_irq   (snd_irq),
        .obj_frame (obj_frame),
        .irq_n     (irq_n)
    );

endmodule

// ==== testbench/tb_clock.sv ====
/*
 * free running testbench clock, 4 ns period, starts low
 */
module tb_clock (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    initial clk = 1'b0;
    always #2 clk = ~clk; // half period
endmodule

// ==== testbench/main_board_tb.sv ====
/*
 * bus cycles are 4 clk long, cen in the last clk, inputs 1 ns after the edge
 * checks are concurrent assertions against a memory map model
 * work ram model keys on the low ram_aw address bits
 */
module main_board_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int ram_aw   = 13;
    localparam int n_bus    = 24 + 64 + 24 + 18 + 23 + 19; // bus cycles, all tests
    localparam int limit_ns = 40 + n_bus * 16 + 400;       // reset + cycles + margin

    logic clk, rst, cpu_cen, rnw, vma, service, lvbl, dip_pause;
    logic vram_cs, objram_cs, snd_data_cs, obj_frame, flip, snd_irq, irq_n;
    logic [1:0] start_button, coin_input;
    logic [2:0] dipsw_c;
    main_pkg::addr_t addr, rom_addr;
    main_pkg::data_t cpu_dout, cpu_din, rom_data, vram_dout, obj_dout;
    main_pkg::joy_t  joystick1, joystick2;
    main_pkg::dip_t  dipsw_a, dipsw_b;

    logic [31:0]     lfsr = 32'hd994_3028;
    main_pkg::data_t ref_ram [int];       // bytes written so far, by ram location
    main_pkg::data_t exp_din;
    logic            rd_known = 1'b0;     // read value predictable
    logic [2:0]      exp_latch = 3'b000;  // flip, snd_irq, obj_frame
    logic [2:0]      exp_cs;              // vram, objram, snd
    logic            exp_irq_n = 1'b1;
    logic            chk_irq = 1'b0;      // irq_n settled
    logic            prev_intst = 1'b0;
    string           test_name = "reset";
    int              errors = 0;
    int              err_start, bus_count, tests_done;
    main_pkg::addr_t wr_addr [32];
    main_pkg::addr_t cs_list [12] = '{16'h2000, 16'h201f, 16'h2040, 16'h27df, 16'h27ff,
        16'h2800, 16'h1000, 16'h13ff, 16'h1500, 16'h157f, 16'h1580, 16'h0fff};
    main_pkg::addr_t open_list [4] = '{16'h0000, 16'h2800, 16'h1580, 16'h1780};

    tb_clock u_clk (.clk(clk));

    main_board #(.ram_aw(ram_aw)) DUT (.*);

    // galois lfsr, one step per bit
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[14:0], lfsr[0]};
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
        end
        return r;
    endfunction

    function automatic logic in_range(input main_pkg::addr_t a, input int lo, input int hi);
        return int'(a) >= lo && int'(a) <= hi;
    endfunction

    function automatic logic in_slot(input main_pkg::addr_t a, input int base);
        return in_range(a, base, base + 127); // 128 byte io slot
    endfunction

    function automatic logic is_ram(input main_pkg::addr_t a);
        return (in_range(a, 'h2000, 'h27ff) && a[5]) || in_range(a, 'h3000, 'h3fff);
    endfunction

    function automatic int ram_key(input main_pkg::addr_t a);
        return int'(a) % (1 << ram_aw); // mirrors like the ram itself
    endfunction

    function automatic main_pkg::data_t rom_model(input main_pkg::addr_t a);
        return a[15:8] ^ a[7:0] ^ 8'h5a;
    endfunction

    // board wiring of one joystick port
    function automatic main_pkg::data_t joy_byte(input main_pkg::joy_t j);
        return {1'b1, j[6:4], j[2], j[3], j[0], j[1]};
    endfunction

    function automatic main_pkg::data_t read_model(input main_pkg::addr_t a);
        if (int'(a) >= 'h4000) return rom_model(a);
        if (is_ram(a)) return ref_ram[ram_key(a)];
        if (in_range(a, 'h2000, 'h27ff)) return vram_dout;
        if (in_range(a, 'h1000, 'h13ff)) return obj_dout;
        if (in_slot(a, 'h1680)) begin
            case (a[1:0])
                2'd0: return {dipsw_c, start_button, service, coin_input};
                2'd1: return joy_byte(joystick1);
                2'd2: return joy_byte(joystick2);
                default: return dipsw_a;
            endcase
        end
        if (in_slot(a, 'h1600)) return dipsw_b;
        return 8'hff; // open bus
    endfunction

    assign rom_data = rom_model(rom_addr); // rom behind the board
    assign exp_cs = {vma && in_range(addr, 'h2000, 'h27ff) && !addr[5],
                     vma && in_range(addr, 'h1000, 'h13ff),
                     vma && in_slot(addr, 'h1500)};

    // one cpu cycle, entered and left 1 ns after a rising edge
    task automatic bus_cycle(input main_pkg::addr_t a, input logic r,
                             input main_pkg::data_t d, input logic valid);
        logic hit_intst;
        hit_intst = valid && in_slot(a, 'h1400);
        addr      = a;
        rnw       = r;
        vma       = valid;
        cpu_dout  = d;
        rd_known  = valid && r && (!is_ram(a) || ref_ram.exists(ram_key(a)));
        exp_din   = rd_known ? read_model(a) : 8'hff;
        repeat (3) @(posedge clk);
        #1 cpu_cen = 1'b1;
        @(posedge clk);
        #1 cpu_cen = 1'b0;
        // effects of the cen edge just passed
        if (valid && !r && is_ram(a))
            ref_ram[ram_key(a)] = d;
        if (valid && !r && in_slot(a, 'h1480)) begin
            case (a[2:0])
                main_pkg::latch_flip:    exp_latch[2] = d[0];
                main_pkg::latch_snd_irq: exp_latch[1] = d[0];
                default: ;
            endcase
        end
        if (hit_intst && !prev_intst)
            exp_latch[0] = ~exp_latch[0]; // rising strobe only
        prev_intst = hit_intst;
        bus_count++;
    endtask

    task automatic idle(input int n);
        repeat (n) bus_cycle(16'h0000, 1'b1, 8'h00, 1'b0);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        err_start = errors;
    endtask

    task automatic end_test();
        tests_done++;
        $display("test %s done, %0d errors", test_name, errors - err_start);
    endtask

    a_reset: assert property (@(posedge clk) $past(rst) |-> cpu_din == 8'hff && irq_n)
    else begin
        errors++;
        $display("Fail reset: cpu_din expected ff actual %h, irq_n expected 1 actual %b",
                 $sampled(cpu_din), $sampled(irq_n));
    end

    a_read: assert property (@(posedge clk) disable iff (rst)
        (cpu_cen && vma && rnw && rd_known) |-> cpu_din == exp_din)
    else begin
        errors++;
        $display("Fail %s: cpu_din at %h expected %h actual %h", test_name,
                 $sampled(addr), $sampled(exp_din), $sampled(cpu_din));
    end

    // read data already holds one clk before cen, two clk after the address
    a_read_settled: assert property (@(posedge clk) disable iff (rst)
        (cpu_cen && vma && rnw && rd_known) |-> $stable(cpu_din))
    else begin
        errors++;
        $display("Error in %s: cpu_din for %h not settled two clk after the address",
                 test_name, $sampled(addr));
    end

    a_rom_addr: assert property (@(posedge clk) disable iff (rst) rom_addr == addr)
    else begin
        errors++;
        $display("Fail %s: rom_addr expected %h actual %h", test_name,
                 $sampled(addr), $sampled(rom_addr));
    end

    a_cs: assert property (@(posedge clk) disable iff (rst)
        {vram_cs, objram_cs, snd_data_cs} == exp_cs)
    else begin
        errors++;
        $display("Fail %s: vram/obj/snd cs at %h expected %b actual %b", test_name,
                 $sampled(addr), $sampled(exp_cs),
                 $sampled({vram_cs, objram_cs, snd_data_cs}));
    end

    a_latch: assert property (@(posedge clk) disable iff (rst)
        {flip, snd_irq, obj_frame} == exp_latch)
    else begin
        errors++;
        $display("Fail %s: flip/snd_irq/obj_frame expected %b actual %b", test_name,
                 $sampled(exp_latch), $sampled({flip, snd_irq, obj_frame}));
    end

    a_irq: assert property (@(posedge clk) disable iff (rst) chk_irq |-> irq_n == exp_irq_n)
    else begin
        errors++;
        $display("Fail %s: irq_n expected %b actual %b", test_name,
                 $sampled(exp_irq_n), $sampled(irq_n));
    end

    // watchdog
    initial begin
        #(limit_ns);
        $display("timeout: tests did not finish within %0d ns", limit_ns);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        main_pkg::addr_t a;
        rst = 1'b1;
        cpu_cen = 1'b0;
        addr = '0;
        rnw = 1'b1;
        vma = 1'b0;
        cpu_dout = '0;
        vram_dout = '0;
        obj_dout = '0;
        {start_button, coin_input, service} = '0;
        joystick1 = '0;
        joystick2 = '0;
        dipsw_a = '0;
        dipsw_b = '0;
        dipsw_c = '0;
        lvbl = 1'b1;      // outside vblank
        dip_pause = 1'b1; // running
        repeat (8) @(posedge clk);
        #1 rst = 1'b0;

        start_test("rom_reads");
        repeat (24) begin
            a = rand_bits(16);
            if (a < main_pkg::rom_base)
                a[15] = 1'b1;
            bus_cycle(a, 1'b1, 8'h00, 1'b1);
        end
        end_test();

        start_test("work_ram");
        for (int i = 0; i < 32; i++) begin
            wr_addr[i] = (i < 16) ? 16'h2020 + rand_bits(5) : 16'h3000 + rand_bits(12);
            bus_cycle(wr_addr[i], 1'b0, 8'(rand_bits(8)), 1'b1);
        end
        for (int i = 0; i < 32; i++)
            bus_cycle(wr_addr[i], 1'b1, 8'h00, 1'b1);
        end_test();

        start_test("chip_selects");
        foreach (cs_list[i]) begin
            vram_dout = 8'(rand_bits(8));
            obj_dout  = 8'(rand_bits(8));
            bus_cycle(cs_list[i], 1'b1, 8'h00, 1'b1);
        end
        repeat (12) begin
            a = 16'h1000 + rand_bits(13); // 0x1000-0x2fff, reads and writes
            vram_dout = 8'(rand_bits(8));
            obj_dout  = 8'(rand_bits(8));
            bus_cycle(a, rand_bits(1) == 16'd1, 8'(rand_bits(8)), 1'b1);
        end
        end_test();

        start_test("cabinet_dips");
        repeat (2) begin
            {start_button, coin_input, service} = 5'(rand_bits(5));
            joystick1 = 7'(rand_bits(7));
            joystick2 = 7'(rand_bits(7));
            dipsw_a = 8'(rand_bits(8));
            dipsw_b = 8'(rand_bits(8));
            dipsw_c = 3'(rand_bits(3));
            for (int i = 0; i < 4; i++)
                bus_cycle(16'h1680 + 16'(i), 1'b1, 8'h00, 1'b1);
            bus_cycle(16'h1600, 1'b1, 8'h00, 1'b1);
            foreach (open_list[i])
                bus_cycle(open_list[i], 1'b1, 8'h00, 1'b1);
        end
        end_test();

        start_test("out_latch");
        repeat (8) bus_cycle(16'h1480 + rand_bits(3), 1'b0, 8'(rand_bits(8)), 1'b1);
        bus_cycle(16'h1480, 1'b0, 8'h01, 1'b1);
        bus_cycle(16'h1481, 1'b0, 8'hff, 1'b1);
        bus_cycle(16'h1480, 1'b1, 8'h00, 1'b1); // read, latch unchanged
        bus_cycle(16'h1480, 1'b0, 8'hfe, 1'b1);
        bus_cycle(16'h1481, 1'b0, 8'h00, 1'b1);
        repeat (4) begin
            bus_cycle(16'h1400, 1'b1, 8'h00, 1'b1); // frame strobe
            bus_cycle(16'h0000, 1'b1, 8'h00, 1'b1);
        end
        bus_cycle(16'h1400, 1'b0, 8'h00, 1'b1);
        bus_cycle(16'h1400, 1'b1, 8'h00, 1'b1);     // back to back, one edge
        end_test();

        start_test("interrupt");
        bus_cycle(16'h1487, 1'b0, 8'h00, 1'b1);     // irq disabled
        idle(1);
        exp_irq_n = 1'b1;
        chk_irq = 1'b1;
        lvbl = 1'b0;                                // vblank, masked
        idle(3);
        lvbl = 1'b1;
        bus_cycle(16'h1487, 1'b0, 8'h01, 1'b1);
        idle(1);
        chk_irq = 1'b0;
        lvbl = 1'b0;                                // trigger edge
        idle(1);
        exp_irq_n = 1'b0;
        chk_irq = 1'b1;
        idle(1);
        lvbl = 1'b1;                                // stays set after vblank
        idle(2);
        chk_irq = 1'b0;
        bus_cycle(16'h1487, 1'b0, 8'h00, 1'b1);     // release
        idle(1);
        exp_irq_n = 1'b1;
        chk_irq = 1'b1;
        bus_cycle(16'h1487, 1'b0, 8'h01, 1'b1);
        dip_pause = 1'b0;                           // paused
        lvbl = 1'b0;
        idle(3);
        lvbl = 1'b1;
        idle(1);
        dip_pause = 1'b1;
        idle(1);
        chk_irq = 1'b0;
        end_test();

        $display("tests %0d, bus cycles %0d, errors %0d", tests_done, bus_count, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

// ==== main_board.f ====
logic/main_pkg.sv
logic/main_if.sv
logic/addr_decoder.sv
logic/work_ram.sv
logic/read_mux.sv
logic/ctrl_latch.sv
logic/main_board.sv
testbench/tb_clock.sv
testbench/main_board_tb.sv

// ==== Makefile ====
# verilator build and run of the main board testbench
VERILATOR ?= verilator
TOP       ?= main_board_tb
FILELIST  ?= main_board.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  := FAIL: see errors above
PASS_MSG  := PASS: all tests

.PHONY: help test clean

help:
	@echo "make test   build with verilator, run, check $(LOG)"
	@echo "make clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "override VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS on the command line"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "run ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
